// File: design/mem_req_pkg.sv
// request field widths and the access kind passed
// from the arbiter to the sequencer

package mem_req_pkg;

    localparam int ADDR_W = 22;  // row + column
    localparam int ROW_W  = 13;
    localparam int COL_W  = 9;
    localparam int BANK_W = 2;

    typedef enum logic [1:0] {
        ACC_NONE    = 2'd0,
        ACC_READ    = 2'd1,
        ACC_WRITE   = 2'd2,
        ACC_REFRESH = 2'd3
    } acc_t;

endpackage

// File: design/sdram_cmd_pkg.sv
// SDRAM command encodings on the control pins,
// mode register fields and the fixed timing counts

package sdram_cmd_pkg;

    // bit order {n_cs, n_ras, n_cas, n_we}
    typedef enum logic [3:0] {
        CMD_LOAD_MODE    = 4'b0000,
        CMD_AUTO_REFRESH = 4'b0001,
        CMD_PRECHARGE    = 4'b0010,
        CMD_ACTIVATE     = 4'b0011,
        CMD_WRITE        = 4'b0100,
        CMD_READ         = 4'b0101,
        CMD_NOP          = 4'b0111,
        CMD_INHIBIT      = 4'b1000  // chip not selected
    } cmd_t;

    localparam logic [13:0] INIT_WAIT = 14'd200;  // kept short for simulation
    localparam int          CAS_LAT   = 2;

    // single write burst, CL2, sequential
    // bit 0 picks the burst: 0 one word, 1 two words
    localparam logic [11:0] MODE_BASE = 12'b00_1_00_010_0_000;

    localparam int REFRESH_IDLE = 3;            // idle slot-zero visits
    localparam int NUM_SLOTS    = 7;            // slots in one access
    localparam int BEAT_SLOT    = 3 + CAS_LAT;  // first read beat sampled here

endpackage

// File: design/sdram_ctrl_top.sv
// SDRAM controller top: arbiter, sequencer and packer
// between the game and download ports and the SDRAM pins

`timescale 1ns/1ps

module sdram_ctrl_top (
    input  logic                           clk,
    input  logic                           rst,
    // game port
    output logic                           loop_rst,
    input  logic                           read_req,
    output logic [31:0]                    data_read,
    input  logic [mem_req_pkg::ADDR_W-1:0] sdram_addr,
    input  logic [mem_req_pkg::BANK_W-1:0] sdram_bank,
    output logic                           data_rdy,
    output logic                           sdram_ack,
    input  logic                           refresh_en,
    input  logic [1:0]                     sdram_wrmask,
    input  logic                           sdram_rnw,
    input  logic [15:0]                    data_write,
    // download port
    input  logic                           downloading,
    input  logic                           prog_we,
    input  logic                           prog_rd,
    input  logic [mem_req_pkg::ADDR_W-1:0] prog_addr,
    input  logic [7:0]                     prog_data,
    input  logic [1:0]                     prog_mask,  // 1 masks a lane
    input  logic [mem_req_pkg::BANK_W-1:0] prog_bank,
    // SDRAM pins
    inout  wire  [15:0]                    sdram_dq,
    output logic [mem_req_pkg::ROW_W-1:0]  sdram_a,
    output logic                           sdram_dqml,
    output logic                           sdram_dqmh,
    output logic                           sdram_n_we,
    output logic                           sdram_n_cas,
    output logic                           sdram_n_ras,
    output logic                           sdram_n_cs,
    output logic [mem_req_pkg::BANK_W-1:0] sdram_ba,
    output logic                           sdram_cke
);

    // arbiter to sequencer
    mem_req_pkg::acc_t              acc_kind;
    logic [mem_req_pkg::ADDR_W-1:0] acc_addr;
    logic [mem_req_pkg::BANK_W-1:0] acc_bank;
    logic [1:0]                     acc_mask;
    logic [15:0]                    acc_wdata;
    logic                           acc_load_mode;
    logic                           acc_burst2;
    logic                           slot_idle;
    logic                           take;
    // sequencer to packer
    logic                           beat_valid;
    logic                           beat_last;
    logic [15:0]                    beat;
    logic                           write_done;

    sdram_req_arb arb (.*);

    sdram_seq seq (.*);

    sdram_rd_pack pack (.*);

endmodule

// File: design/sdram_rd_pack.sv
// read-beat packer: joins the beats of a read into one
// 32-bit word and pulses data ready for reads and writes

`timescale 1ns/1ps

module sdram_rd_pack (
    input  logic        clk,
    input  logic        rst,
    input  logic        beat_valid,
    input  logic        beat_last,
    input  logic [15:0] beat,
    input  logic        write_done,
    output logic [31:0] data_read,
    output logic        data_rdy
);

    logic [15:0] first_q;  // first beat, goes to the upper half
    logic        pair;     // a first beat is waiting

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pair     <= 1'b0;
            data_rdy <= 1'b0;
        end else begin
            data_rdy <= (beat_valid && beat_last) || write_done;
            if (beat_valid)
                pair <= !beat_last;
        end
    end

    always_ff @(posedge clk) begin
        if (beat_valid && !beat_last)
            first_q <= beat;
        if (beat_valid && beat_last)
            data_read <= {pair ? first_q : beat, beat};  // single beat copied up
    end

endmodule

// File: design/sdram_req_arb.sv
// request arbiter: mode reload, download port, game port
// and idle refresh, in that order of priority

`timescale 1ns/1ps

module sdram_req_arb (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           downloading,
    input  logic                           prog_we,
    input  logic                           prog_rd,
    input  logic [mem_req_pkg::ADDR_W-1:0] prog_addr,
    input  logic [mem_req_pkg::BANK_W-1:0] prog_bank,
    input  logic [1:0]                     prog_mask,
    input  logic [7:0]                     prog_data,
    input  logic                           read_req,
    input  logic                           sdram_rnw,
    input  logic [mem_req_pkg::ADDR_W-1:0] sdram_addr,
    input  logic [mem_req_pkg::BANK_W-1:0] sdram_bank,
    input  logic [1:0]                     sdram_wrmask,
    input  logic [15:0]                    data_write,
    input  logic                           refresh_en,
    input  logic                           slot_idle,
    input  logic                           take,
    output mem_req_pkg::acc_t              acc_kind,
    output logic [mem_req_pkg::ADDR_W-1:0] acc_addr,
    output logic [mem_req_pkg::BANK_W-1:0] acc_bank,
    output logic [1:0]                     acc_mask,
    output logic [15:0]                    acc_wdata,
    output logic                           acc_load_mode,
    output logic                           acc_burst2,
    output logic                           sdram_ack
);

    logic dl_we;      // registered download strobes
    logic dl_rd;
    logic dl_last;    // downloading, one cycle late
    logic reload;     // mode reload pending
    logic burst_sel;
    logic [$clog2(sdram_cmd_pkg::REFRESH_IDLE+1)-1:0] idle_cnt;
    logic refresh_req;

    assign refresh_req = idle_cnt == sdram_cmd_pkg::REFRESH_IDLE;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            dl_we     <= 1'b0;
            dl_rd     <= 1'b0;
            dl_last   <= 1'b0;
            reload    <= 1'b0;
            burst_sel <= 1'b1;  // power-up mode is burst 2
            idle_cnt  <= '0;
            sdram_ack <= 1'b0;
        end else begin
            dl_we     <= downloading && prog_we;
            dl_rd     <= downloading && prog_rd;
            dl_last   <= downloading;
            sdram_ack <= take && (acc_kind == mem_req_pkg::ACC_READ ||
                                  acc_kind == mem_req_pkg::ACC_WRITE);
            if (take && acc_load_mode)
                reload <= 1'b0;
            if (downloading != dl_last) begin  // a new edge wins over the clear
                reload    <= 1'b1;
                burst_sel <= !downloading;     // single beats while downloading
            end
            // any slot-zero work restarts the idle count
            if (!refresh_en || take)
                idle_cnt <= '0;
            else if (slot_idle && !refresh_req)
                idle_cnt <= idle_cnt + 1'b1;
        end
    end

    always_comb begin
        acc_load_mode = reload;
        acc_burst2    = burst_sel;
        acc_kind      = mem_req_pkg::ACC_NONE;
        if (dl_last) begin  // download fields, byte on both lanes
            acc_addr  = prog_addr;
            acc_bank  = prog_bank;
            acc_mask  = prog_mask;
            acc_wdata = {prog_data, prog_data};
        end else begin
            acc_addr  = sdram_addr;
            acc_bank  = sdram_bank;
            acc_mask  = sdram_wrmask;
            acc_wdata = data_write;
        end
        if (reload)
            acc_kind = mem_req_pkg::ACC_NONE;  // load mode goes alone
        else if (dl_we || dl_rd)
            acc_kind = dl_we ? mem_req_pkg::ACC_WRITE : mem_req_pkg::ACC_READ;
        else if (read_req && !downloading)
            acc_kind = sdram_rnw ? mem_req_pkg::ACC_READ : mem_req_pkg::ACC_WRITE;
        else if (refresh_req)
            acc_kind = mem_req_pkg::ACC_REFRESH;
    end

endmodule

// File: design/sdram_seq.sv
// SDRAM command sequencer: power-up steps, then a one-hot
// slot loop that runs one access, refresh or mode load at a time

`timescale 1ns/1ps

module sdram_seq (
    input  logic                           clk,
    input  logic                           rst,
    input  mem_req_pkg::acc_t              acc_kind,
    input  logic [mem_req_pkg::ADDR_W-1:0] acc_addr,
    input  logic [mem_req_pkg::BANK_W-1:0] acc_bank,
    input  logic [1:0]                     acc_mask,
    input  logic [15:0]                    acc_wdata,
    input  logic                           acc_load_mode,
    input  logic                           acc_burst2,
    output logic                           slot_idle,
    output logic                           take,
    output logic                           loop_rst,
    output logic                           beat_valid,
    output logic                           beat_last,
    output logic [15:0]                    beat,
    output logic                           write_done,
    output logic [mem_req_pkg::ROW_W-1:0]  sdram_a,
    output logic [mem_req_pkg::BANK_W-1:0] sdram_ba,
    output logic                           sdram_dqml,
    output logic                           sdram_dqmh,
    output logic                           sdram_n_cs,
    output logic                           sdram_n_ras,
    output logic                           sdram_n_cas,
    output logic                           sdram_n_we,
    output logic                           sdram_cke,
    inout  wire  [15:0]                    sdram_dq
);

    sdram_cmd_pkg::cmd_t                  cmd;
    logic [13:0]                          wait_cnt;   // power-up and init gaps
    logic [2:0]                           init_step;
    logic [sdram_cmd_pkg::NUM_SLOTS-1:0]  slot;       // one-hot
    logic                                 rd_cyc;
    logic                                 wr_cyc;
    logic                                 burst2_q;   // burst length now loaded
    logic                                 dq_oe;
    logic [mem_req_pkg::COL_W-1:0]        col_q;
    logic [1:0]                           mask_q;
    logic [15:0]                          wdata_q;

    assign {sdram_n_cs, sdram_n_ras, sdram_n_cas, sdram_n_we} = cmd;
    assign sdram_cke = 1'b1;
    assign sdram_dq  = dq_oe ? wdata_q : 16'hzzzz;
    assign slot_idle = slot[0] && !loop_rst;
    assign take      = slot_idle && (acc_load_mode || acc_kind != mem_req_pkg::ACC_NONE);

    // access payload, held for the whole slot loop
    always_ff @(posedge clk) begin
        if (take) begin
            col_q   <= acc_addr[mem_req_pkg::COL_W-1:0];
            mask_q  <= acc_mask;
            wdata_q <= acc_wdata;
        end
        if (rd_cyc && (slot[sdram_cmd_pkg::BEAT_SLOT] || slot[sdram_cmd_pkg::BEAT_SLOT+1]))
            beat <= sdram_dq;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cmd        <= sdram_cmd_pkg::CMD_NOP;
            sdram_a    <= '0;
            sdram_ba   <= '0;
            sdram_dqmh <= 1'b0;
            sdram_dqml <= 1'b0;
            wait_cnt   <= sdram_cmd_pkg::INIT_WAIT;
            init_step  <= 3'd0;
            loop_rst   <= 1'b1;
            slot       <= 1;
            rd_cyc     <= 1'b0;
            wr_cyc     <= 1'b0;
            burst2_q   <= 1'b1;
            dq_oe      <= 1'b0;
            beat_valid <= 1'b0;
            beat_last  <= 1'b0;
            write_done <= 1'b0;
        end else if (loop_rst) begin
            cmd <= sdram_cmd_pkg::CMD_NOP;  // nop between init steps
            if (wait_cnt != 14'd0) begin
                wait_cnt <= wait_cnt - 14'd1;
            end else begin
                init_step <= init_step + 3'd1;
                case (init_step)
                    3'd0: begin
                        cmd         <= sdram_cmd_pkg::CMD_PRECHARGE;
                        sdram_a[10] <= 1'b1;  // all banks
                        wait_cnt    <= 14'd2;
                    end
                    3'd1: begin
                        cmd      <= sdram_cmd_pkg::CMD_AUTO_REFRESH;
                        wait_cnt <= 14'd11;
                    end
                    3'd2: begin
                        cmd      <= sdram_cmd_pkg::CMD_LOAD_MODE;
                        sdram_a  <= {1'b0, sdram_cmd_pkg::MODE_BASE[11:1], 1'b1};
                        wait_cnt <= 14'd3;
                    end
                    3'd3: begin
                        cmd         <= sdram_cmd_pkg::CMD_PRECHARGE;
                        sdram_a[10] <= 1'b1;
                        wait_cnt    <= 14'd4;
                    end
                    default: loop_rst <= 1'b0;  // into the slot loop at slot zero
                endcase
            end
        end else begin
            cmd        <= sdram_cmd_pkg::CMD_NOP;
            beat_valid <= 1'b0;
            beat_last  <= 1'b0;
            write_done <= 1'b0;
            // slot zero waits for work, the rest run freely
            if (!slot[0] || take)
                slot <= {slot[sdram_cmd_pkg::NUM_SLOTS-2:0], slot[sdram_cmd_pkg::NUM_SLOTS-1]};
            if (take) begin
                rd_cyc     <= !acc_load_mode && acc_kind == mem_req_pkg::ACC_READ;
                wr_cyc     <= !acc_load_mode && acc_kind == mem_req_pkg::ACC_WRITE;
                sdram_dqmh <= 1'b0;
                sdram_dqml <= 1'b0;
                if (acc_load_mode) begin
                    cmd      <= sdram_cmd_pkg::CMD_LOAD_MODE;
                    sdram_a  <= {1'b0, sdram_cmd_pkg::MODE_BASE[11:1], acc_burst2};
                    burst2_q <= acc_burst2;
                    slot     <= 1 << (sdram_cmd_pkg::NUM_SLOTS - 1);  // one nop slot
                end else if (acc_kind == mem_req_pkg::ACC_REFRESH) begin
                    cmd <= sdram_cmd_pkg::CMD_AUTO_REFRESH;
                end else begin
                    cmd      <= sdram_cmd_pkg::CMD_ACTIVATE;
                    sdram_a  <= acc_addr[mem_req_pkg::ADDR_W-1:mem_req_pkg::COL_W];  // row
                    sdram_ba <= acc_bank;
                end
            end
            if (slot[2] && (rd_cyc || wr_cyc)) begin
                cmd     <= wr_cyc ? sdram_cmd_pkg::CMD_WRITE : sdram_cmd_pkg::CMD_READ;
                sdram_a <= {4'b0010, col_q};  // A10 high, auto precharge
                {sdram_dqmh, sdram_dqml} <= wr_cyc ? mask_q : 2'b00;  // reads take both bytes
                dq_oe   <= wr_cyc;
            end
            if (slot[3])
                dq_oe <= 1'b0;  // write data held one cycle only
            if (slot[sdram_cmd_pkg::BEAT_SLOT]) begin
                beat_valid <= rd_cyc;
                beat_last  <= rd_cyc && !burst2_q;
                write_done <= wr_cyc;
            end
            if (slot[sdram_cmd_pkg::BEAT_SLOT+1] && rd_cyc && burst2_q) begin
                beat_valid <= 1'b1;  // second beat of the pair
                beat_last  <= 1'b1;
            end
        end
    end

endmodule

// File: tests/sdram_ctrl_properties.sv
// pin protocol checks on the sequencer
// init commands only and activate to read or write spacing

`timescale 1ns/1ps

module sdram_ctrl_properties (
    input logic clk,
    input logic rst,
    input logic loop_rst,
    input logic sdram_n_cs,
    input logic sdram_n_ras,
    input logic sdram_n_cas,
    input logic sdram_n_we
);

    logic [3:0] cmd;

    assign cmd = {sdram_n_cs, sdram_n_ras, sdram_n_cas, sdram_n_we};

    // power-up steps use only these
    init_cmds_only: assert property (@(posedge clk) disable iff (rst)
        loop_rst |-> cmd inside {sdram_cmd_pkg::CMD_NOP, sdram_cmd_pkg::CMD_PRECHARGE,
                                 sdram_cmd_pkg::CMD_AUTO_REFRESH, sdram_cmd_pkg::CMD_LOAD_MODE})
        else $error("command other than nop or init step during power-up");

    act_gap: assert property (@(posedge clk) disable iff (rst)
        cmd == sdram_cmd_pkg::CMD_ACTIVATE |=>
            !(cmd inside {sdram_cmd_pkg::CMD_READ, sdram_cmd_pkg::CMD_WRITE}))
        else $error("read or write one cycle after activate");

    rw_after_act: assert property (@(posedge clk) disable iff (rst)
        cmd inside {sdram_cmd_pkg::CMD_READ, sdram_cmd_pkg::CMD_WRITE} |->
            $past(cmd, 2) == sdram_cmd_pkg::CMD_ACTIVATE)
        else $error("read or write without activate two cycles before");

endmodule

bind sdram_seq sdram_ctrl_properties props (.*);

// File: tests/sdram_ctrl_tb.sv
// testbench for the SDRAM controller with clock, reset and LFSR
// stimulus table with reference memory, latency and data checks

`timescale 1ns/1ps

module sdram_ctrl_tb;

    typedef enum logic [2:0] {
        OP_DL_WR, OP_DL_RD, OP_GAME_WR, OP_GAME_RD, OP_SET_DL, OP_SET_REF, OP_IDLE
    } op_t;

    typedef struct packed {
        op_t         op;
        logic [21:0] addr;
        logic [1:0]  bank;
        logic [1:0]  mask;
        logic [15:0] data;   // cycles for OP_IDLE, level for OP_SET_*
        logic [31:0] exp;
    } step_t;

    logic        clk, rst, loop_rst, read_req, data_rdy, sdram_ack, refresh_en, sdram_rnw;
    logic        downloading, prog_we, prog_rd;
    logic [31:0] data_read;
    logic [21:0] sdram_addr, prog_addr;
    logic [1:0]  sdram_bank, sdram_wrmask, prog_bank, prog_mask;
    logic [15:0] data_write;
    logic [7:0]  prog_data;
    wire  [15:0] sdram_dq;
    logic [12:0] sdram_a;
    logic [1:0]  sdram_ba;
    logic        sdram_dqml, sdram_dqmh, sdram_n_we, sdram_n_cas, sdram_n_ras, sdram_n_cs;
    logic        sdram_cke;

    step_t       steps[$];
    logic [15:0] ref_mem [logic [23:0]];  // key {bank, addr}
    logic [31:0] lfsr;
    int          cyc = 0;
    int          ack_cnt = 0;
    int          rdy_cnt = 0;
    int          ref_cnt = 0;  // auto-refresh commands after init

    sdram_ctrl_top uut (.*);

    sdram_model chip (
        .clk(clk), .cke(sdram_cke), .n_cs(sdram_n_cs), .n_ras(sdram_n_ras),
        .n_cas(sdram_n_cas), .n_we(sdram_n_we), .ba(sdram_ba), .a(sdram_a),
        .dqml(sdram_dqml), .dqmh(sdram_dqmh), .dq(sdram_dq)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) cyc <= cyc + 1;

    task automatic abort_run(input string line);
        $display("%s", line);
        $display("RESULT: FAIL");
        $fatal(1, "run stopped");
    endtask

    // outputs watched mid-cycle
    always @(negedge clk) begin
        if (sdram_ack)
            ack_cnt++;
        if (data_rdy)
            rdy_cnt++;
        if ({sdram_n_cs, sdram_n_ras, sdram_n_cas, sdram_n_we} ==
            sdram_cmd_pkg::CMD_AUTO_REFRESH && !loop_rst)
            ref_cnt++;
        if (!rst)
            assert (!(loop_rst && sdram_ack)) else
                abort_run("sdram_ack was given while loop_rst was still high");
    end

    // fibonacci taps 32 22 2 1 stepped once per bit
    function automatic logic [31:0] draw(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
            v = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic logic [15:0] ref_word(input logic [23:0] key);
        return ref_mem.exists(key) ? ref_mem[key] : 16'h0000;
    endfunction

    function automatic logic [15:0] merge(input logic [15:0] old, input logic [15:0] d,
                                          input logic [1:0] mask);
        logic [15:0] w;
        w = old;
        if (!mask[0])
            w[7:0] = d[7:0];   // mask bit set keeps the old byte
        if (!mask[1])
            w[15:8] = d[15:8];
        return w;
    endfunction

    // appends one row with expected read data from the reference memory
    task automatic add_step(input op_t op, input logic [21:0] addr, input logic [1:0] bank,
                            input logic [1:0] mask, input logic [15:0] data);
        step_t       s;
        logic [23:0] key;
        key = {bank, addr};
        s   = '{op, addr, bank, mask, data, 32'h0};
        case (op)
            OP_DL_WR:   ref_mem[key] = merge(ref_word(key), {data[7:0], data[7:0]}, mask);
            OP_GAME_WR: ref_mem[key] = merge(ref_word(key), data, mask);
            OP_DL_RD:   s.exp = {ref_word(key), ref_word(key)};  // beat on both halves
            OP_GAME_RD: s.exp = {ref_word(key), ref_word({bank, addr[21:1], 1'b1})};
            default: ;
        endcase
        steps.push_back(s);
    endtask

    task automatic run_access(input step_t s);
        int ack_cyc;
        int lat;
        bit got;
        @(posedge clk);
        if (s.op == OP_DL_WR || s.op == OP_DL_RD) begin
            prog_addr <= s.addr;
            prog_bank <= s.bank;
            prog_mask <= s.mask;
            prog_data <= s.data[7:0];
            prog_we   <= s.op == OP_DL_WR;
            prog_rd   <= s.op == OP_DL_RD;
        end else begin
            sdram_addr   <= s.addr;
            sdram_bank   <= s.bank;
            sdram_wrmask <= s.mask;
            data_write   <= s.data;
            sdram_rnw    <= s.op == OP_GAME_RD;
            read_req     <= 1'b1;
        end
        got = 0;
        for (int i = 0; i < 100 && !got; i++) begin
            @(negedge clk);
            got = sdram_ack;
        end
        if (!got)
            abort_run("timeout waiting for sdram_ack");
        ack_cyc = cyc;
        @(posedge clk);
        prog_we  <= 1'b0;  // request dropped after the ack
        prog_rd  <= 1'b0;
        read_req <= 1'b0;
        got = 0;
        for (int i = 0; i < 20 && !got; i++) begin
            @(negedge clk);
            got = data_rdy;
        end
        if (!got)
            abort_run("timeout waiting for data_rdy");
        lat = (s.op == OP_GAME_RD) ? 7 : 6;
        assert (cyc - ack_cyc == lat) else
            abort_run($sformatf("Fail at %0t: data_rdy %0d cycles after sdram_ack, expected %0d",
                                $time, cyc - ack_cyc, lat));
        if (s.op == OP_GAME_RD || s.op == OP_DL_RD)
            assert (data_read == s.exp) else
                abort_run($sformatf("Fail at %0t: read bank %0d addr %h got %h expected %h",
                                    $time, s.bank, s.addr, data_read, s.exp));
        @(posedge clk);
        assert (ack_cnt == rdy_cnt) else
            abort_run($sformatf("Fail at %0t: %0d acks but %0d data_rdy pulses",
                                $time, ack_cnt, rdy_cnt));
    endtask

    task automatic apply_step(input step_t s);
        int n0;
        case (s.op)
            OP_SET_DL: begin
                @(posedge clk);
                downloading <= s.data[0];
                repeat (10) @(posedge clk);  // let the mode reload settle
            end
            OP_SET_REF: begin
                @(posedge clk);
                refresh_en <= s.data[0];
            end
            OP_IDLE: begin
                n0 = ref_cnt;
                repeat (s.data) @(negedge clk);
                assert (ref_cnt > n0 && ack_cnt == rdy_cnt) else
                    abort_run($sformatf("Fail at %0t: no auto-refresh seen while idle", $time));
            end
            default: run_access(s);
        endcase
    endtask

    initial begin
        logic [31:0] r;
        logic [21:0] a;
        logic [1:0]  b;
        bit          got;
        rst = 1'b1;
        downloading = 1'b0;
        prog_we = 1'b0;
        prog_rd = 1'b0;
        prog_addr = '0;
        prog_bank = '0;
        prog_mask = '0;
        prog_data = '0;
        read_req = 1'b1;  // game read pending across power-up
        sdram_rnw = 1'b1;
        sdram_addr = '0;
        sdram_bank = '0;
        sdram_wrmask = '0;
        data_write = '0;
        refresh_en = 1'b0;
        lfsr = 32'h0ba8f11f;

        // the pending read is taken once loop_rst falls
        add_step(OP_GAME_RD, 22'h0, 2'd0, 2'b00, 16'h0);
        // download bytes then burst-2 game traffic with refresh on
        add_step(OP_SET_DL, 22'h0, 2'd0, 2'b00, 16'd1);
        add_step(OP_DL_WR, 22'h10, 2'd2, 2'b00, 16'h0011);
        add_step(OP_DL_WR, 22'h10, 2'd2, 2'b01, 16'h00a5);  // upper byte only
        add_step(OP_DL_WR, 22'h11, 2'd2, 2'b10, 16'h003c);  // lower byte only
        add_step(OP_DL_RD, 22'h10, 2'd2, 2'b00, 16'h0);
        add_step(OP_DL_RD, 22'h11, 2'd2, 2'b00, 16'h0);
        add_step(OP_SET_DL, 22'h0, 2'd0, 2'b00, 16'd0);
        add_step(OP_SET_REF, 22'h0, 2'd0, 2'b00, 16'd1);
        add_step(OP_IDLE, 22'h0, 2'd0, 2'b00, 16'd40);
        add_step(OP_GAME_RD, 22'h10, 2'd2, 2'b00, 16'h0);
        add_step(OP_GAME_WR, 22'h20, 2'd1, 2'b00, 16'h1234);
        add_step(OP_GAME_WR, 22'h21, 2'd1, 2'b00, 16'hbeef);
        add_step(OP_GAME_RD, 22'h20, 2'd1, 2'b00, 16'h0);
        add_step(OP_GAME_WR, 22'h21, 2'd1, 2'b10, 16'h0055);
        add_step(OP_GAME_RD, 22'h20, 2'd1, 2'b00, 16'h0);
        for (int k = 0; k < 6; k++) begin
            r = draw(21);
            a = {r[20:0], 1'b0};  // even word for a pair read
            r = draw(2);
            b = r[1:0];
            r = draw(16);
            add_step(OP_GAME_WR, a, b, 2'b00, r[15:0]);
            r = draw(16);
            add_step(OP_GAME_WR, a | 22'h1, b, 2'b00, r[15:0]);
            r = draw(18);
            add_step(OP_GAME_WR, a, b, r[17:16], r[15:0]);
            add_step(OP_GAME_RD, a, b, 2'b00, 16'h0);
        end
        add_step(OP_IDLE, 22'h0, 2'd0, 2'b00, 16'd30);

        repeat (3) @(posedge clk);
        rst <= 1'b0;
        got = 0;
        for (int i = 0; i < sdram_cmd_pkg::INIT_WAIT + 40 && !got; i++) begin
            @(negedge clk);
            got = !loop_rst;
        end
        if (!got)
            abort_run("timeout waiting for loop_rst to fall after reset");

        foreach (steps[i])
            apply_step(steps[i]);

        $display("RESULT: PASS");
        $finish;
    end

endmodule

// File: tests/sdram_model.sv
// behavioral SDR SDRAM chip: CL2 reads, burst 1 or 2 from the mode
// register, byte masks on writes, sparse word memory

`timescale 1ns/1ps

module sdram_model (
    input  logic        clk,
    input  logic        cke,
    input  logic        n_cs,
    input  logic        n_ras,
    input  logic        n_cas,
    input  logic        n_we,
    input  logic [1:0]  ba,
    input  logic [12:0] a,
    input  logic        dqml,
    input  logic        dqmh,
    inout  wire  [15:0] dq
);

    logic [15:0] mem [logic [23:0]];  // key {bank, row, col}
    logic [12:0] open_row [4];
    logic [3:0]  cmd;
    logic        burst2 = 1'b1;
    logic        rd_pending = 1'b0;   // read seen, data one edge later
    logic        rd_idx = 1'b0;       // next beat of the pair
    logic        dq_oe = 1'b0;
    logic [15:0] dq_out;
    logic [23:0] rd_key;
    logic [23:0] wr_key;
    logic [15:0] wr_word;

    assign cmd = {n_cs, n_ras, n_cas, n_we};
    assign dq  = dq_oe ? dq_out : 16'hzzzz;

    // unwritten words read as zero
    function automatic logic [15:0] word_at(input logic [23:0] key);
        return mem.exists(key) ? mem[key] : 16'h0000;
    endfunction

    always @(posedge clk) begin
        if (cke) begin
            if (rd_pending) begin
                dq_out <= word_at(rd_key);  // valid at the CL2 edge
                dq_oe  <= 1'b1;
                rd_idx <= 1'b1;
            end else if (dq_oe && rd_idx && burst2) begin
                dq_out <= word_at({rd_key[23:1], !rd_key[0]});  // sequential wrap of 2
                rd_idx <= 1'b0;
            end else begin
                dq_oe <= 1'b0;
            end
            rd_pending <= 1'b0;
            case (cmd)
                sdram_cmd_pkg::CMD_LOAD_MODE: burst2 <= a[0];
                sdram_cmd_pkg::CMD_ACTIVATE:  open_row[ba] <= a;
                sdram_cmd_pkg::CMD_READ: begin
                    rd_key     <= {ba, open_row[ba], a[8:0]};
                    rd_pending <= 1'b1;
                end
                sdram_cmd_pkg::CMD_WRITE: begin
                    wr_key  = {ba, open_row[ba], a[8:0]};
                    wr_word = word_at(wr_key);
                    if (!dqml)
                        wr_word[7:0] = dq[7:0];   // mask high blocks the lane
                    if (!dqmh)
                        wr_word[15:8] = dq[15:8];
                    mem[wr_key] = wr_word;
                end
                default: ;
            endcase
        end
    end

endmodule

// File: vlog.f
design/sdram_cmd_pkg.sv
design/mem_req_pkg.sv
design/sdram_req_arb.sv
design/sdram_seq.sv
design/sdram_rd_pack.sv
design/sdram_ctrl_top.sv
tests/sdram_model.sv
tests/sdram_ctrl_properties.sv
tests/sdram_ctrl_tb.sv
